/* noc_axis_switch.f */
noc_pkg.sv
flit_fifo.sv
rr_arbiter.sv
axis_flit_packer.sv
flit_switch.sv
flit_axis_unpacker.sv
noc_axis_switch.sv
tb_noc_axis_switch.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_noc_axis_switch
FILELIST  = noc_axis_switch.f
LOG       = sim.log
FAIL_MSG  = tests failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* tb_noc_axis_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_axis_switch import noc_pkg::*; ();

   localparam int num_tests    = 6;
   localparam int max_beats    = 32;
   localparam int test_timeout = 3000;
   localparam int stall_cycles = 80;

   logic       clk;
   logic       rst;
   data_t      s_tdata [num_ports];
   dest_t      s_tdest [num_ports];
   user_t      s_tuser [num_ports];
   port_mask_t s_tvalid;
   port_mask_t s_tlast;
   port_mask_t s_tready;
   data_t      m_tdata [num_ports];
   keep_t      m_tkeep [num_ports];
   dest_t      m_tdest [num_ports];
   user_t      m_tuser [num_ports];
   port_mask_t m_tvalid;
   port_mask_t m_tlast;
   port_mask_t m_tready;

   // per test: which inputs send, then per input dest, user and byte length
   port_mask_t t_send [num_tests] = '{4'b0001, 4'b0010, 4'b1111, 4'b1111, 4'b1111, 4'b1111};
   dest_t t_dest [num_tests][num_ports] = '{
      '{2'd2, 2'd0, 2'd0, 2'd0}, '{2'd0, 2'd0, 2'd0, 2'd0}, '{2'd1, 2'd2, 2'd3, 2'd0},
      '{2'd1, 2'd1, 2'd1, 2'd1}, '{2'd3, 2'd0, 2'd2, 2'd1}, '{2'd3, 2'd3, 2'd3, 2'd3}};
   user_t t_user [num_tests][num_ports] = '{
      '{1'b1, 1'b0, 1'b0, 1'b0}, '{1'b0, 1'b1, 1'b0, 1'b0}, '{1'b0, 1'b1, 1'b1, 1'b0},
      '{1'b1, 1'b0, 1'b1, 1'b0}, '{1'b1, 1'b1, 1'b0, 1'b0}, '{1'b0, 1'b1, 1'b0, 1'b1}};
   len_t t_len [num_tests][num_ports] = '{
      '{16'd13, 16'd0, 16'd0, 16'd0}, '{16'd0, 16'd0, 16'd0, 16'd0},
      '{16'd0, 16'd8, 16'd13, 16'd40}, '{16'd40, 16'd13, 16'd8, 16'd24},
      '{16'd40, 16'd21, 16'd64, 16'd5}, '{16'd120, 16'd96, 16'd77, 16'd130}};
   // m_axis_tready: 0 always high, 1 random stall, 2 long stall at the start
   int t_mode [num_tests] = '{0, 0, 0, 0, 1, 2};

   // scoreboard, expected beats kept per source
   data_t      exp_data [num_ports][max_beats];
   int         exp_beats [num_ports];
   int         drv_idx [num_ports];
   int         cur_src [num_ports];
   int         cur_beat [num_ports];
   port_mask_t rcv_done;
   int         cur_test;
   integer     seed = 32'h754d32b4;
   int         checks;
   int         errors;
   logic       timed_out;

   noc_axis_switch uut (
      .clk             (clk),
      .rst             (rst),
      .s_axis_tdata_i  (s_tdata),
      .s_axis_tdest_i  (s_tdest),
      .s_axis_tuser_i  (s_tuser),
      .s_axis_tvalid_i (s_tvalid),
      .s_axis_tlast_i  (s_tlast),
      .s_axis_tready_o (s_tready),
      .m_axis_tdata_o  (m_tdata),
      .m_axis_tkeep_o  (m_tkeep),
      .m_axis_tdest_o  (m_tdest),
      .m_axis_tuser_o  (m_tuser),
      .m_axis_tvalid_o (m_tvalid),
      .m_axis_tlast_o  (m_tlast),
      .m_axis_tready_i (m_tready)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // head beat plus one beat per started group of eight bytes
   function automatic int beats_for(input len_t len);
      beats_for = 1 + (int'(len) + keep_width - 1) / keep_width;
   endfunction

   // head all ones, body full until fewer than eight bytes remain
   function automatic keep_t expected_keep(input len_t len, input int beat);
      int remaining;
      remaining = int'(len) - keep_width * (beat - 1);
      if (beat == 0 || remaining >= keep_width)
         expected_keep = '1;
      else
         expected_keep = keep_t'((1 << remaining) - 1);
   endfunction

   task automatic report(input string what, input int o, input int b,
                         input logic [63:0] got, input logic [63:0] exp);
      errors++;
      $display("Error at time %0t: %s on output %0d beat %0d is %0h, expected %0h",
               $time, what, o, b, got, exp);
   endtask

   task automatic check_data(input int o, input int b, input data_t got, input data_t exp);
      checks++;
      if (got !== exp)
         report("tdata", o, b, got, exp);
   endtask

   task automatic check_keep(input int o, input int b, input keep_t got, input keep_t exp);
      checks++;
      if (got !== exp)
         report("tkeep", o, b, 64'(got), 64'(exp));
   endtask

   task automatic check_dest(input int o, input int b, input dest_t got, input dest_t exp);
      checks++;
      if (got !== exp)
         report("tdest", o, b, 64'(got), 64'(exp));
   endtask

   task automatic check_user(input int o, input int b, input user_t got, input user_t exp);
      checks++;
      if (got !== exp)
         report("tuser", o, b, 64'(got), 64'(exp));
   endtask

   task automatic check_last(input int o, input int b, input logic got, input logic exp);
      checks++;
      if (got !== exp)
         report("tlast", o, b, 64'(got), 64'(exp));
   endtask

   // whole-port flags such as tready and tvalid between tests
   task automatic check_mask(input string what, input port_mask_t got, input port_mask_t exp);
      checks++;
      if (got !== exp)
         report(what, -1, -1, 64'(got), 64'(exp));
   endtask

   // head carries length in bits 15:0 and the source port in bits 23:16
   task automatic build_packets(input int t);
      data_t d;
      for (int p = 0; p < num_ports; p++) begin
         exp_beats[p] = 0;
         if (t_send[t][p]) begin
            exp_beats[p] = beats_for(t_len[t][p]);
            d = {$random(seed), $random(seed)};
            d[23:0] = {8'(p), t_len[t][p]};
            exp_data[p][0] = d;
            for (int b = 1; b < exp_beats[p]; b++)
               exp_data[p][b] = {$random(seed), $random(seed)};
         end
      end
   endtask

   task automatic drive_inputs();
      for (int p = 0; p < num_ports; p++) begin
         if (drv_idx[p] < exp_beats[p]) begin
            s_tvalid[p] = 1'b1;
            s_tdata[p]  = exp_data[p][drv_idx[p]];
            s_tlast[p]  = (drv_idx[p] == exp_beats[p] - 1);
            if (drv_idx[p] == 0) begin
               s_tdest[p] = t_dest[cur_test][p];
               s_tuser[p] = t_user[cur_test][p];
            end else begin
               // body beats carry other side-band, outputs must keep the head values
               s_tdest[p] = ~t_dest[cur_test][p];
               s_tuser[p] = ~t_user[cur_test][p];
            end
         end else begin
            s_tvalid[p] = 1'b0;
            s_tlast[p]  = 1'b0;
         end
      end
   endtask

   task automatic drive_ready(input int cycles);
      case (t_mode[cur_test])
         0:       m_tready = '1;
         1:       m_tready = port_mask_t'($random(seed));
         default: m_tready = (cycles < stall_cycles) ? '0 : '1;
      endcase
   endtask

   // source field of the head picks the packet, later beats must follow it
   task automatic check_beat(input int o);
      int src;
      int b;
      if (cur_src[o] < 0) begin
         src = int'(m_tdata[o][23:16]);
         if (src >= num_ports || !t_send[cur_test][src] || rcv_done[src]
             || int'(t_dest[cur_test][src]) != o) begin
            report("head source", o, 0, 64'(src), 64'(0));
            return;
         end
         cur_src[o]  = src;
         cur_beat[o] = 0;
      end
      src = cur_src[o];
      b   = cur_beat[o];
      check_data(o, b, m_tdata[o], exp_data[src][b]);
      check_keep(o, b, m_tkeep[o], expected_keep(t_len[cur_test][src], b));
      check_dest(o, b, m_tdest[o], t_dest[cur_test][src]);
      check_user(o, b, m_tuser[o], t_user[cur_test][src]);
      check_last(o, b, m_tlast[o], b == exp_beats[src] - 1);
      if (b == exp_beats[src] - 1) begin
         rcv_done[src] = 1'b1;
         cur_src[o]    = -1;
      end else begin
         cur_beat[o] = b + 1;
      end
   endtask

   // drive on the falling edge, sample 1 ns later while everything is stable
   task automatic run_test(input int t);
      int         cycles;
      int         err_start;
      port_mask_t accepted;
      logic       saw_backpressure;
      err_start        = errors;
      cur_test         = t;
      accepted         = '0;
      saw_backpressure = 1'b0;
      cycles           = 0;
      build_packets(t);
      rcv_done = ~t_send[t];
      for (int p = 0; p < num_ports; p++) begin
         drv_idx[p] = 0;
         cur_src[p] = -1;
      end
      while (rcv_done != '1 && cycles < test_timeout) begin
         @(negedge clk);
         for (int p = 0; p < num_ports; p++) begin
            if (accepted[p])
               drv_idx[p]++;
         end
         drive_inputs();
         drive_ready(cycles);
         #1;
         if (cycles == 0) begin
            check_mask("idle s_axis_tready", s_tready, '1);
            check_mask("idle m_axis_tvalid", m_tvalid, '0);
         end
         accepted = s_tvalid & s_tready;
         if ((s_tvalid & ~s_tready) != '0)
            saw_backpressure = 1'b1;
         for (int o = 0; o < num_ports; o++) begin
            if (m_tvalid[o] && m_tready[o])
               check_beat(o);
         end
         cycles++;
      end
      if (rcv_done != '1) begin
         timed_out = 1'b1;
         errors++;
         for (int p = 0; p < num_ports; p++) begin
            if (!rcv_done[p])
               $display("timeout in test %0d: packet from input %0d never completed at output %0d",
                        t, p, t_dest[t][p]);
         end
      end else if (t_mode[t] == 2 && !saw_backpressure) begin
         errors++;
         $display("Error at time %0t: s_axis_tready never dropped during the long stall",
                  $time);
      end
      if (errors == err_start)
         $display("test %0d passed after %0d cycles", t, cycles);
      else
         $display("test %0d failed with %0d errors", t, errors - err_start);
   endtask

   initial begin
      rst       = 1'b1;
      s_tvalid  = '0;
      s_tlast   = '0;
      m_tready  = '0;
      checks    = 0;
      errors    = 0;
      timed_out = 1'b0;
      for (int p = 0; p < num_ports; p++) begin
         s_tdata[p] = '0;
         s_tdest[p] = '0;
         s_tuser[p] = '0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int t = 0; t < num_tests && !timed_out; t++)
         run_test(t);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* noc_axis_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module noc_axis_switch import noc_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  data_t      s_axis_tdata_i [num_ports],
   input  dest_t      s_axis_tdest_i [num_ports],
   input  user_t      s_axis_tuser_i [num_ports],
   input  port_mask_t s_axis_tvalid_i,
   input  port_mask_t s_axis_tlast_i,
   output port_mask_t s_axis_tready_o,
   output data_t      m_axis_tdata_o [num_ports],
   output keep_t      m_axis_tkeep_o [num_ports],
   output dest_t      m_axis_tdest_o [num_ports],
   output user_t      m_axis_tuser_o [num_ports],
   output port_mask_t m_axis_tvalid_o,
   output port_mask_t m_axis_tlast_o,
   input  port_mask_t m_axis_tready_i
);

   // packers into switch queues
   port_mask_t in_valid, in_head, in_tail, in_credit;
   data_t      in_data [num_ports];
   dest_t      in_dest [num_ports];
   user_t      in_user [num_ports];

   // switch outputs into unpackers
   port_mask_t out_valid, out_head, out_tail, out_credit;
   data_t      out_data [num_ports];
   dest_t      out_dest [num_ports];
   user_t      out_user [num_ports];

   for (genvar p = 0; p < num_ports; p++) begin : g_port
      axis_flit_packer u_packer (
         .clk             (clk),
         .rst             (rst),
         .s_axis_tdata_i  (s_axis_tdata_i[p]),
         .s_axis_tvalid_i (s_axis_tvalid_i[p]),
         .s_axis_tlast_i  (s_axis_tlast_i[p]),
         .s_axis_tdest_i  (s_axis_tdest_i[p]),
         .s_axis_tuser_i  (s_axis_tuser_i[p]),
         .s_axis_tready_o (s_axis_tready_o[p]),
         .flit_valid_o    (in_valid[p]),
         .flit_head_o     (in_head[p]),
         .flit_tail_o     (in_tail[p]),
         .flit_data_o     (in_data[p]),
         .flit_dest_o     (in_dest[p]),
         .flit_user_o     (in_user[p]),
         .credit_i        (in_credit[p])
      );

      flit_axis_unpacker u_unpacker (
         .clk             (clk),
         .rst             (rst),
         .flit_valid_i    (out_valid[p]),
         .flit_head_i     (out_head[p]),
         .flit_tail_i     (out_tail[p]),
         .flit_data_i     (out_data[p]),
         .flit_dest_i     (out_dest[p]),
         .flit_user_i     (out_user[p]),
         .credit_o        (out_credit[p]),
         .m_axis_tdata_o  (m_axis_tdata_o[p]),
         .m_axis_tkeep_o  (m_axis_tkeep_o[p]),
         .m_axis_tvalid_o (m_axis_tvalid_o[p]),
         .m_axis_tlast_o  (m_axis_tlast_o[p]),
         .m_axis_tdest_o  (m_axis_tdest_o[p]),
         .m_axis_tuser_o  (m_axis_tuser_o[p]),
         .m_axis_tready_i (m_axis_tready_i[p])
      );
   end

   flit_switch u_switch (
      .clk          (clk),
      .rst          (rst),
      .in_valid_i   (in_valid),
      .in_head_i    (in_head),
      .in_tail_i    (in_tail),
      .in_data_i    (in_data),
      .in_dest_i    (in_dest),
      .in_user_i    (in_user),
      .in_credit_o  (in_credit),
      .out_valid_o  (out_valid),
      .out_head_o   (out_head),
      .out_tail_o   (out_tail),
      .out_data_o   (out_data),
      .out_dest_o   (out_dest),
      .out_user_o   (out_user),
      .out_credit_i (out_credit)
   );

endmodule

`default_nettype wire

/* flit_axis_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_axis_unpacker import noc_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  logic  flit_valid_i,
   input  logic  flit_head_i,
   input  logic  flit_tail_i,
   input  data_t flit_data_i,
   input  dest_t flit_dest_i,
   input  user_t flit_user_i,
   output logic  credit_o,
   output data_t m_axis_tdata_o,
   output keep_t m_axis_tkeep_o,
   output logic  m_axis_tvalid_o,
   output logic  m_axis_tlast_o,
   output dest_t m_axis_tdest_o,
   output user_t m_axis_tuser_o,
   input  logic  m_axis_tready_i
);

   // buffer word is data, keep, last, dest, user
   logic [data_width+keep_width+$bits(dest_t)+$bits(user_t):0] push_word;
   logic [data_width+keep_width+$bits(dest_t)+$bits(user_t):0] pop_word;
   flit_kind_e   kind;
   frame_state_e state_q;
   len_t         remain_q;
   len_t         remain_d;
   dest_t        dest_q;
   dest_t        dest_d;
   user_t        user_q;
   user_t        user_d;
   keep_t        keep;
   logic         empty;
   logic         pop;

   assign kind = flit_kind_e'(flit_head_i);

   always_comb begin
      keep     = '1;
      remain_d = remain_q;
      dest_d   = dest_q;
      user_d   = user_q;
      if (kind == flit_head) begin
         // head beat is all valid and carries the byte count
         remain_d = flit_data_i[len_width-1:0];
         dest_d   = flit_dest_i;
         user_d   = flit_user_i;
      end else if (remain_q >= len_t'(keep_width)) begin
         remain_d = remain_q - len_t'(keep_width);
      end else begin
         // last body beat, remainder in the low bytes
         keep     = ~({keep_width{1'b1}} << remain_q);
         remain_d = '0;
      end
   end

   assign push_word = {flit_data_i, keep, flit_tail_i, dest_d, user_d};

   // credits toward the switch cover these slots, so no full check
   flit_fifo #(.width($bits(push_word))) u_buf (
      .clk         (clk),
      .rst         (rst),
      .push_i      (flit_valid_i),
      .push_data_i (push_word),
      .pop_i       (pop),
      .head_data_o (pop_word),
      .empty_o     (empty),
      .full_o      ()
   );

   assign {m_axis_tdata_o, m_axis_tkeep_o, m_axis_tlast_o, m_axis_tdest_o, m_axis_tuser_o}
      = pop_word;
   assign m_axis_tvalid_o = !empty;
   assign pop             = m_axis_tvalid_o && m_axis_tready_i;
   // slot leaves on the handshake, hand it back to the switch
   assign credit_o        = pop;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= frame_head;
      end else if (flit_valid_i) begin
         state_q <= flit_tail_i ? frame_head : frame_body;
      end
   end

   // packet context only changes on a valid flit
   always_ff @(posedge clk) begin
      if (flit_valid_i) begin
         remain_q <= remain_d;
         dest_q   <= dest_d;
         user_q   <= user_d;
      end
   end

   // switch lock must keep packets whole on this output
   assert property (@(posedge clk) disable iff (rst)
      flit_valid_i |-> ((kind == flit_head) == (state_q == frame_head)));

endmodule

`default_nettype wire

/* flit_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_switch import noc_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  port_mask_t in_valid_i,
   input  port_mask_t in_head_i,
   input  port_mask_t in_tail_i,
   input  data_t      in_data_i [num_ports],
   input  dest_t      in_dest_i [num_ports],
   input  user_t      in_user_i [num_ports],
   output port_mask_t in_credit_o,
   output port_mask_t out_valid_o,
   output port_mask_t out_head_o,
   output port_mask_t out_tail_o,
   output data_t      out_data_o [num_ports],
   output dest_t      out_dest_o [num_ports],
   output user_t      out_user_o [num_ports],
   input  port_mask_t out_credit_i
);

   // queue word is data, dest, user, tail, head from msb down
   logic [data_width+$bits(dest_t)+$bits(user_t)+1:0] q_word [num_ports];
   data_t      q_data [num_ports];
   dest_t      q_dest [num_ports];
   user_t      q_user [num_ports];
   flit_kind_e q_kind [num_ports];
   port_mask_t q_head;
   port_mask_t q_tail;
   port_mask_t q_empty;
   port_mask_t pop;

   // per output state
   port_mask_t req [num_ports];
   port_mask_t grant [num_ports];
   port_mask_t lock_q;
   dest_t      owner_q [num_ports];
   dest_t      sel [num_ports];
   credit_t    credit_q [num_ports];
   port_mask_t send;
   port_mask_t advance;

   for (genvar i = 0; i < num_ports; i++) begin : g_in
      flit_fifo #(.width($bits(q_word[0]))) u_queue (
         .clk         (clk),
         .rst         (rst),
         .push_i      (in_valid_i[i]),
         .push_data_i ({in_data_i[i], in_dest_i[i], in_user_i[i], in_tail_i[i], in_head_i[i]}),
         .pop_i       (pop[i]),
         .head_data_o (q_word[i]),
         .empty_o     (q_empty[i]),
         .full_o      ()
      );
      assign {q_data[i], q_dest[i], q_user[i], q_tail[i], q_head[i]} = q_word[i];
      assign q_kind[i] = flit_kind_e'(q_head[i]);
   end

   // only a waiting head flit asks for a free output that has credit
   always_comb begin
      for (int o = 0; o < num_ports; o++) begin
         for (int i = 0; i < num_ports; i++) begin
            req[o][i] = !q_empty[i] && (q_kind[i] == flit_head) && (q_dest[i] == dest_t'(o))
                        && !lock_q[o] && (credit_q[o] != '0);
         end
      end
   end

   for (genvar o = 0; o < num_ports; o++) begin : g_out
      rr_arbiter u_arb (
         .clk       (clk),
         .rst       (rst),
         .req_i     (req[o]),
         .advance_i (advance[o]),
         .grant_o   (grant[o])
      );

      assert property (@(posedge clk) disable iff (rst)
         credit_q[o] <= credit_t'(buffer_depth));
   end

   // locked output follows its owner, free output follows the new grant
   always_comb begin
      pop     = '0;
      send    = '0;
      advance = '0;
      for (int o = 0; o < num_ports; o++) begin
         sel[o] = owner_q[o];
         for (int i = 0; i < num_ports; i++) begin
            if (grant[o][i]) sel[o] = dest_t'(i);
         end
         if (lock_q[o]) begin
            send[o] = !q_empty[owner_q[o]] && (credit_q[o] != '0);
         end else begin
            send[o] = (grant[o] != '0);
         end
         advance[o] = send[o] && q_tail[sel[o]];
         if (send[o]) pop[sel[o]] = 1'b1;
      end
   end

   // each pop frees a queue slot upstream
   assign in_credit_o = pop;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_o <= '0;
         lock_q      <= '0;
         for (int o = 0; o < num_ports; o++) begin
            owner_q[o]  <= '0;
            credit_q[o] <= credit_t'(buffer_depth);
         end
      end else begin
         out_valid_o <= send;
         for (int o = 0; o < num_ports; o++) begin
            // hold the output until the tail has gone through
            if (send[o]) begin
               lock_q[o]  <= !q_tail[sel[o]];
               owner_q[o] <= sel[o];
            end
            case ({send[o], out_credit_i[o]})
               2'b10:   credit_q[o] <= credit_q[o] - 1'b1;
               2'b01:   credit_q[o] <= credit_q[o] + 1'b1;
               default: credit_q[o] <= credit_q[o];
            endcase
         end
      end
   end

   // registered output flit, one cycle after the pop
   always_ff @(posedge clk) begin
      for (int o = 0; o < num_ports; o++) begin
         if (send[o]) begin
            out_head_o[o] <= q_head[sel[o]];
            out_tail_o[o] <= q_tail[sel[o]];
            out_data_o[o] <= q_data[sel[o]];
            out_dest_o[o] <= q_dest[sel[o]];
            out_user_o[o] <= q_user[sel[o]];
         end
      end
   end

endmodule

`default_nettype wire

/* axis_flit_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_flit_packer import noc_pkg::*; (
   input  logic  clk,
   input  logic  rst,
   input  data_t s_axis_tdata_i,
   input  logic  s_axis_tvalid_i,
   input  logic  s_axis_tlast_i,
   input  dest_t s_axis_tdest_i,
   input  user_t s_axis_tuser_i,
   output logic  s_axis_tready_o,
   output logic  flit_valid_o,
   output logic  flit_head_o,
   output logic  flit_tail_o,
   output data_t flit_data_o,
   output dest_t flit_dest_o,
   output user_t flit_user_o,
   input  logic  credit_i
);

   frame_state_e state_q;
   credit_t      credit_q;
   logic         fire;

   // one credit per free slot in the switch queue
   assign s_axis_tready_o = (credit_q != '0);
   assign fire            = s_axis_tvalid_i && s_axis_tready_o;

   // beat goes straight out as a flit, queue writes it on this edge
   assign flit_valid_o = fire;
   assign flit_head_o  = (state_q == frame_head);
   assign flit_tail_o  = s_axis_tlast_i;
   assign flit_data_o  = s_axis_tdata_i;
   assign flit_dest_o  = s_axis_tdest_i;
   assign flit_user_o  = s_axis_tuser_i;

   // head marker follows the beats of each packet
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= frame_head;
      end else if (fire) begin
         state_q <= s_axis_tlast_i ? frame_head : frame_body;
      end
   end

   // spend on send, refund on credit return, both may land together
   always_ff @(posedge clk) begin
      if (rst) begin
         credit_q <= credit_t'(buffer_depth);
      end else begin
         case ({fire, credit_i})
            2'b10:   credit_q <= credit_q - 1'b1;
            2'b01:   credit_q <= credit_q + 1'b1;
            default: credit_q <= credit_q;
         endcase
      end
   end

   // switch never returns more credits than flits it was given
   assert property (@(posedge clk) disable iff (rst)
      credit_i |-> credit_q != credit_t'(buffer_depth));

endmodule

`default_nettype wire

/* rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter import noc_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  port_mask_t req_i,
   input  logic       advance_i,
   output port_mask_t grant_o
);

   // port that last finished a packet, search starts just after it
   dest_t last_q;
   // port granted most recently, still owning the output
   dest_t served_q;
   dest_t grant_idx;

   // walk from farthest to nearest so the nearest requester wins
   always_comb begin
      dest_t idx;
      grant_o   = '0;
      grant_idx = last_q;
      for (int i = num_ports; i >= 1; i--) begin
         idx = dest_t'(int'(last_q) + i);
         if (req_i[idx]) begin
            grant_o      = '0;
            grant_o[idx] = 1'b1;
            grant_idx    = idx;
         end
      end
   end

   // pointer only moves once the tail is gone
   // single flit packets grant and finish in the same cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         last_q   <= dest_t'(num_ports - 1);
         served_q <= '0;
      end else begin
         if (grant_o != '0) served_q <= grant_idx;
         if (advance_i) last_q <= (grant_o != '0) ? grant_idx : served_q;
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      $onehot0(grant_o) && ((grant_o & ~req_i) == '0));

endmodule

`default_nettype wire

/* flit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_fifo import noc_pkg::*; #(
   parameter int width = 8
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             push_i,
   input  logic [width-1:0] push_data_i,
   input  logic             pop_i,
   output logic [width-1:0] head_data_o,
   output logic             empty_o,
   output logic             full_o
);

   logic [width-1:0] mem [buffer_depth];
   logic [$clog2(buffer_depth)-1:0] wr_ptr;
   logic [$clog2(buffer_depth)-1:0] rd_ptr;
   logic [$clog2(buffer_depth+1)-1:0] count;

   // storage has no reset, only the pointers do
   always_ff @(posedge clk) begin
      if (push_i) mem[wr_ptr] <= push_data_i;
   end

   // depth is a power of two so the pointers wrap by themselves
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) wr_ptr <= wr_ptr + 1'b1;
         if (pop_i) rd_ptr <= rd_ptr + 1'b1;
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // show-ahead, oldest entry always on the output
   assign head_data_o = mem[rd_ptr];
   assign empty_o     = (count == '0);
   assign full_o      = (count == buffer_depth);

   // the credit scheme upstream must never overrun or underrun us
   assert property (@(posedge clk) disable iff (rst)
      !(push_i && full_o) && !(pop_i && empty_o));

endmodule

`default_nettype wire

/* noc_pkg.sv */
`default_nettype none

package noc_pkg;

   // port count, shared by inputs and outputs
   localparam int num_ports = 4;

   // stream data path
   localparam int data_width = 64;
   localparam int keep_width = data_width / 8;

   // flit slots per switch queue and per output buffer
   localparam int buffer_depth = 8;

   // byte length field sits in the low bits of the head beat
   localparam int len_width = 16;

   typedef logic [data_width-1:0] data_t;
   typedef logic [keep_width-1:0] keep_t;
   typedef logic [$clog2(num_ports)-1:0] dest_t;
   typedef logic [0:0] user_t;
   typedef logic [len_width-1:0] len_t;
   // counts 0 to buffer_depth inclusive
   typedef logic [$clog2(buffer_depth+1)-1:0] credit_t;
   typedef logic [num_ports-1:0] port_mask_t;

   // position of the next beat within a packet
   typedef enum logic {
      frame_head = 1'b0,
      frame_body = 1'b1
   } frame_state_e;

   // head flag as carried on flit ports
   typedef enum logic {
      flit_body = 1'b0,
      flit_head = 1'b1
   } flit_kind_e;

endpackage

`default_nettype wire
